// File: src/rv_core_pkg.sv
package rv_core_pkg;

  localparam int XLEN = 32;
  localparam int NUM_REGS = 32; // x0 included

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0] reg_addr_t;
  typedef logic [3:0] wmask_t; // one bit per byte lane

  // major opcode field, inst[6:0]
  typedef enum logic [6:0] {
    OP_OTHER  = 7'b000_0000, // anything the core does not implement
    OP_LOAD   = 7'b000_0011,
    OP_IMM    = 7'b001_0011,
    OP_AUIPC  = 7'b001_0111,
    OP_STORE  = 7'b010_0011,
    OP_LUI    = 7'b011_0111,
    OP_JALR   = 7'b110_0111,
    OP_JAL    = 7'b110_1111,
    OP_SYSTEM = 7'b111_0011
  } opcode_e;

  // funct3 of loads and stores
  // stores only use the signed codes
  typedef enum logic [2:0] {
    MW_B  = 3'b000,
    MW_H  = 3'b001,
    MW_W  = 3'b010,
    MW_BU = 3'b100,
    MW_HU = 3'b101
  } mem_width_e;

  localparam word_t RESET_PC = 32'h8000_0000;
  localparam word_t PC_STEP = 32'd4; // static next pc
  localparam word_t EBREAK_INST = 32'h0010_0073;

endpackage

// File: src/decode_if.sv
`timescale 1ns/1ps

// one decoded instruction, refreshed every cycle
interface decode_if;

  rv_core_pkg::opcode_e op;
  rv_core_pkg::reg_addr_t rd;
  rv_core_pkg::reg_addr_t rs1;
  rv_core_pkg::reg_addr_t rs2;
  rv_core_pkg::mem_width_e width; // funct3 for loads and stores
  rv_core_pkg::word_t imm; // final immediate for the format
  logic is_ebreak;

  modport src (
    output op,
    output rd,
    output rs1,
    output rs2,
    output width,
    output imm,
    output is_ebreak
  );

  modport dst (
    input op,
    input rd,
    input rs1,
    input rs2,
    input width,
    input imm,
    input is_ebreak
  );

endinterface

// File: src/rf_if.sv
`timescale 1ns/1ps

interface rf_if;

  rv_core_pkg::reg_addr_t rs1_addr;
  rv_core_pkg::reg_addr_t rs2_addr;
  rv_core_pkg::word_t rs1_data;
  rv_core_pkg::word_t rs2_data;
  logic wen;
  rv_core_pkg::reg_addr_t waddr;
  rv_core_pkg::word_t wdata;

  // register file side
  modport rf (
    input rs1_addr, rs2_addr, wen, waddr, wdata,
    output rs1_data, rs2_data
  );

  modport user (
    output rs1_addr, rs2_addr, wen, waddr, wdata,
    input rs1_data, rs2_data
  );

endinterface

// File: src/inst_decode.sv
`timescale 1ns/1ps

module inst_decode (
  input rv_core_pkg::word_t inst,
  decode_if.src dec
);

  rv_core_pkg::opcode_e op;
  rv_core_pkg::word_t imm_i;
  rv_core_pkg::word_t imm_s;
  rv_core_pkg::word_t imm_j;
  rv_core_pkg::word_t imm_u;

  // known opcodes pass through, the rest collapse to OP_OTHER
  always_comb begin
    case (inst[6:0])
      rv_core_pkg::OP_LUI,
      rv_core_pkg::OP_AUIPC,
      rv_core_pkg::OP_JAL,
      rv_core_pkg::OP_JALR,
      rv_core_pkg::OP_LOAD,
      rv_core_pkg::OP_STORE,
      rv_core_pkg::OP_IMM,
      rv_core_pkg::OP_SYSTEM: op = rv_core_pkg::opcode_e'(inst[6:0]);
      default: op = rv_core_pkg::OP_OTHER; // branches land here too
    endcase
  end

  // immediates for each format, all sign extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'h000}; // already shifted

  always_comb begin
    case (op)
      rv_core_pkg::OP_LUI,
      rv_core_pkg::OP_AUIPC: dec.imm = imm_u;
      rv_core_pkg::OP_JAL:   dec.imm = imm_j;
      rv_core_pkg::OP_STORE: dec.imm = imm_s;
      default:               dec.imm = imm_i; // addi, jalr, loads
    endcase
  end

  assign dec.op = op;
  assign dec.rd = inst[11:7];
  assign dec.rs1 = inst[19:15];
  assign dec.rs2 = inst[24:20];

  // unused codes keep their raw value and give a zero mask in the lsu
  assign dec.width = rv_core_pkg::mem_width_e'(inst[14:12]);

  assign dec.is_ebreak = (inst == rv_core_pkg::EBREAK_INST);

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input logic clk,
  rf_if.rf rf
);

  rv_core_pkg::word_t regs [rv_core_pkg::NUM_REGS];

  logic write_ok;

  // x0 is never written
  assign write_ok = rf.wen && (rf.waddr != '0);

  always_ff @(posedge clk) begin
    if (write_ok) begin
      regs[rf.waddr] <= rf.wdata;
    end
  end

  // reads are combinational, x0 forced to zero
  assign rf.rs1_data = (rf.rs1_addr == '0) ? '0 : regs[rf.rs1_addr];
  assign rf.rs2_data = (rf.rs2_addr == '0) ? '0 : regs[rf.rs2_addr];

endmodule

// File: src/lsu_align.sv
`timescale 1ns/1ps

module lsu_align (
  input rv_core_pkg::mem_width_e width,
  input logic [1:0] byte_off,
  input rv_core_pkg::word_t store_data,
  input rv_core_pkg::word_t rdata,
  output rv_core_pkg::word_t wdata,
  output rv_core_pkg::wmask_t wmask,
  output rv_core_pkg::word_t load_data
);

  rv_core_pkg::word_t lane; // addressed lane moved down to bit 0

  assign lane = rdata >> {byte_off, 3'b000};

  // store side
  always_comb begin
    case (width)
      rv_core_pkg::MW_B: begin
        wdata = {4{store_data[7:0]}}; // every lane carries the byte
        wmask = 4'b0001 << byte_off;
      end
      rv_core_pkg::MW_H: begin
        wdata = {2{store_data[15:0]}};
        wmask = byte_off[0] ? 4'b0000 : (4'b0011 << byte_off);
      end
      rv_core_pkg::MW_W: begin
        wdata = store_data;
        wmask = (byte_off == 2'b00) ? 4'b1111 : 4'b0000;
      end
      default: begin
        wdata = store_data;
        wmask = 4'b0000; // no such store width
      end
    endcase
  end

  // load side
  always_comb begin
    case (width)
      rv_core_pkg::MW_B:  load_data = {{24{lane[7]}}, lane[7:0]};
      rv_core_pkg::MW_BU: load_data = {24'h00_0000, lane[7:0]};
      rv_core_pkg::MW_H: begin
        load_data = byte_off[0] ? '0 : {{16{lane[15]}}, lane[15:0]};
      end
      rv_core_pkg::MW_HU: begin
        load_data = byte_off[0] ? '0 : {16'h0000, lane[15:0]};
      end
      rv_core_pkg::MW_W:  load_data = (byte_off == 2'b00) ? rdata : '0;
      default:            load_data = '0;
    endcase
  end

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input logic clk,
  input logic rst,
  decode_if.dst dec,
  rf_if.user rf,
  output rv_core_pkg::word_t pc,
  output rv_core_pkg::word_t mem_addr,
  output logic mem_ren,
  output logic mem_wen,
  output rv_core_pkg::word_t mem_wdata,
  output rv_core_pkg::wmask_t mem_wmask,
  input rv_core_pkg::word_t mem_rdata,
  output logic halt
);

  logic halted_q; // sticky after ebreak until reset
  logic is_load;
  logic is_store;
  logic no_write;
  rv_core_pkg::word_t op_a;
  rv_core_pkg::word_t sum;
  rv_core_pkg::word_t pc_seq;
  rv_core_pkg::word_t next_pc;
  rv_core_pkg::word_t load_data;
  rv_core_pkg::wmask_t lane_mask;

  assign is_load = (dec.op == rv_core_pkg::OP_LOAD);
  assign is_store = (dec.op == rv_core_pkg::OP_STORE);
  assign halt = halted_q | dec.is_ebreak;

  // first adder operand, the second is always the immediate
  always_comb begin
    case (dec.op)
      rv_core_pkg::OP_AUIPC,
      rv_core_pkg::OP_JAL: op_a = pc;
      rv_core_pkg::OP_LUI:  op_a = '0;
      default:              op_a = rf.rs1_data;
    endcase
  end

  assign sum = op_a + dec.imm;
  assign pc_seq = pc + rv_core_pkg::PC_STEP;

  always_comb begin
    case (dec.op)
      rv_core_pkg::OP_JAL:  next_pc = sum;
      rv_core_pkg::OP_JALR: next_pc = {sum[31:1], 1'b0};
      default:              next_pc = pc_seq; // includes unsupported ops
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= rv_core_pkg::RESET_PC;
      halted_q <= 1'b0;
    end else begin
      if (!halt) pc <= next_pc;
      if (dec.is_ebreak) halted_q <= 1'b1;
    end
  end

  lsu_align lsu_i (
    .width(dec.width),
    .byte_off(sum[1:0]),
    .store_data(rf.rs2_data),
    .rdata(mem_rdata),
    .wdata(mem_wdata),
    .wmask(lane_mask),
    .load_data(load_data)
  );

  // memory gets the word address, lanes are picked by the mask
  assign mem_addr = {sum[31:2], 2'b00};
  assign mem_ren = is_load;
  assign mem_wen = is_store && !halt;
  assign mem_wmask = mem_wen ? lane_mask : 4'b0000;

  // writeback
  assign no_write = is_store || (dec.op == rv_core_pkg::OP_SYSTEM) ||
                    (dec.op == rv_core_pkg::OP_OTHER);
  assign rf.rs1_addr = dec.rs1;
  assign rf.rs2_addr = dec.rs2;
  assign rf.waddr = dec.rd;
  assign rf.wen = !rst && !halt && !no_write; // retire only outside reset

  always_comb begin
    case (dec.op)
      rv_core_pkg::OP_JAL,
      rv_core_pkg::OP_JALR: rf.wdata = pc_seq; // link address
      rv_core_pkg::OP_LOAD: rf.wdata = load_data;
      default:              rf.wdata = sum;
    endcase
  end

endmodule

// File: src/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
  input logic clk,
  input logic rst,
  input rv_core_pkg::word_t inst,
  input rv_core_pkg::word_t mem_rdata,
  output rv_core_pkg::word_t pc,
  output rv_core_pkg::word_t mem_addr,
  output logic mem_ren,
  output logic mem_wen,
  output rv_core_pkg::word_t mem_wdata,
  output rv_core_pkg::wmask_t mem_wmask,
  output logic halt
);

  decode_if dec_bus ();
  rf_if rf_bus ();

  // decoded op for the current inst
  inst_decode decode_i (
    .inst(inst),
    .dec(dec_bus.src)
  );

  reg_file rf_i (
    .clk(clk),
    .rf(rf_bus.rf)
  );

  // pc, alu, memory and writeback
  exec_unit exec_i (
    .clk(clk),
    .rst(rst),
    .dec(dec_bus.dst),
    .rf(rf_bus.user),
    .pc(pc),
    .mem_addr(mem_addr),
    .mem_ren(mem_ren),
    .mem_wen(mem_wen),
    .mem_wdata(mem_wdata),
    .mem_wmask(mem_wmask),
    .mem_rdata(mem_rdata),
    .halt(halt)
  );

endmodule

// File: bench/core_chk.sv
`timescale 1ns/1ps

module core_chk (
  input logic clk,
  input logic rst,
  input rv_core_pkg::word_t pc,
  input logic mem_ren,
  input logic mem_wen,
  input rv_core_pkg::wmask_t mem_wmask,
  input logic halt
);

  // a load and a store never share a cycle
  ren_wen_excl: assert property (@(posedge clk) !(mem_ren && mem_wen))
    else $error("mem_ren and mem_wen high together");

  mask_idle: assert property (@(posedge clk) !mem_wen |-> (mem_wmask == 4'b0000))
    else $error("mem_wmask set without mem_wen");

  pc_held: assert property (@(posedge clk) disable iff (rst) halt |=> $stable(pc))
    else $error("pc moved while halted");

  // pc lands on the reset vector the cycle after reset
  pc_reset: assert property (@(posedge clk) rst |=> (pc == rv_core_pkg::RESET_PC))
    else $error("pc not at reset vector after reset");

endmodule

bind rv_core_top core_chk chk_i (.*);

// File: bench/core_tb.sv
`timescale 1ns/1ps

module core_tb;

  logic clk;
  logic rst;
  rv_core_pkg::word_t inst;
  rv_core_pkg::word_t mem_rdata;
  rv_core_pkg::word_t pc;
  rv_core_pkg::word_t mem_addr;
  logic mem_ren;
  logic mem_wen;
  rv_core_pkg::word_t mem_wdata;
  rv_core_pkg::wmask_t mem_wmask;
  logic halt;

  rv_core_pkg::word_t mem [0:255]; // 1 KiB, indexed by byte address bits 9:2
  rv_core_pkg::word_t lfsr_q;
  rv_core_pkg::word_t exp_pc; // where the next issued inst should sit
  string test_name;

  rv_core_top dut_i (
    .clk(clk),
    .rst(rst),
    .inst(inst),
    .mem_rdata(mem_rdata),
    .pc(pc),
    .mem_addr(mem_addr),
    .mem_ren(mem_ren),
    .mem_wen(mem_wen),
    .mem_wdata(mem_wdata),
    .mem_wmask(mem_wmask),
    .halt(halt)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  function automatic rv_core_pkg::word_t fill_word(input rv_core_pkg::word_t a);
    return {~a[9:2], a[9:2], 6'h2b, a[9:0]};
  endfunction

  function automatic rv_core_pkg::word_t merge_lanes(input rv_core_pkg::word_t old,
      input rv_core_pkg::word_t nw, input rv_core_pkg::wmask_t mask);
    rv_core_pkg::word_t bm;
    bm = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (old & ~bm) | (nw & bm);
  endfunction

  // data memory, combinational read, masked write at the edge
  assign mem_rdata = mem[mem_addr[9:2]];

  always @(posedge clk) begin
    rv_core_pkg::word_t a;
    if (rst) begin
      for (int w = 0; w < 256; w++) begin
        a = rv_core_pkg::word_t'(w) << 2;
        mem[a[9:2]] <= fill_word(a);
      end
    end else if (mem_wen) begin
      mem[mem_addr[9:2]] <= merge_lanes(mem[mem_addr[9:2]], mem_wdata, mem_wmask);
    end
  end

  // galois lfsr, one step per bit taken
  function automatic rv_core_pkg::word_t rand_bits(input int n);
    rv_core_pkg::word_t v;
    logic b;
    v = '0;
    for (int k = 0; k < n; k++) begin
      b = lfsr_q[0];
      lfsr_q = lfsr_q >> 1;
      if (b) lfsr_q = lfsr_q ^ 32'h8020_0003;
      v = {v[30:0], b};
    end
    return v;
  endfunction

  function automatic rv_core_pkg::word_t asm_i(input rv_core_pkg::word_t imm,
      input rv_core_pkg::reg_addr_t rs1, input logic [2:0] f3,
      input rv_core_pkg::reg_addr_t rd, input rv_core_pkg::opcode_e op);
    return {imm[11:0], rs1, f3, rd, op};
  endfunction

  function automatic rv_core_pkg::word_t asm_s(input rv_core_pkg::word_t imm,
      input rv_core_pkg::reg_addr_t rs2, input rv_core_pkg::reg_addr_t rs1,
      input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], rv_core_pkg::OP_STORE};
  endfunction

  function automatic rv_core_pkg::word_t asm_u(input rv_core_pkg::word_t imm,
      input rv_core_pkg::reg_addr_t rd, input rv_core_pkg::opcode_e op);
    return {imm[19:0], rd, op};
  endfunction

  function automatic rv_core_pkg::word_t asm_j(input rv_core_pkg::word_t off,
      input rv_core_pkg::reg_addr_t rd);
    return {off[20], off[10:1], off[11], off[19:12], rd, rv_core_pkg::OP_JAL};
  endfunction

  function automatic rv_core_pkg::word_t nop();
    return asm_i('0, 5'd0, 3'b000, 5'd0, rv_core_pkg::OP_IMM);
  endfunction

  function automatic rv_core_pkg::word_t sext12(input rv_core_pkg::word_t v);
    return {{20{v[11]}}, v[11:0]};
  endfunction

  // the lane a load picks, extended as its width says
  function automatic rv_core_pkg::word_t load_expect(input rv_core_pkg::word_t w,
      input rv_core_pkg::mem_width_e width, input int off);
    rv_core_pkg::word_t sh;
    sh = w >> (8 * off);
    case (width)
      rv_core_pkg::MW_B:  return {{24{sh[7]}}, sh[7:0]};
      rv_core_pkg::MW_BU: return {24'h00_0000, sh[7:0]};
      rv_core_pkg::MW_H:  return {{16{sh[15]}}, sh[15:0]};
      rv_core_pkg::MW_HU: return {16'h0000, sh[15:0]};
      default:            return w;
    endcase
  endfunction

  task automatic stop_on_error();
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_word(input string what, input rv_core_pkg::word_t exp,
      input rv_core_pkg::word_t act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_mask(input string what, input rv_core_pkg::wmask_t exp,
      input rv_core_pkg::wmask_t act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_pc(input string what, input rv_core_pkg::word_t exp,
      input rv_core_pkg::word_t act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected pc %h, actual pc %h", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  task automatic check_bit(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
      stop_on_error();
    end
  endtask

  // the inst on the bus retires at the edge, then the new one is presented
  task automatic issue(input rv_core_pkg::word_t i);
    @(posedge clk);
    #0.5;
    inst = i;
    #1;
    check_pc("pc", exp_pc, pc);
    exp_pc = exp_pc + rv_core_pkg::PC_STEP;
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    repeat (16) @(posedge clk);
    #0.5;
    rst = 1'b0;
    #1;
    check_pc("reset pc", rv_core_pkg::RESET_PC, pc);
    exp_pc = rv_core_pkg::RESET_PC + rv_core_pkg::PC_STEP; // pending inst retires next
  endtask

  task automatic store_and_check(input string what, input rv_core_pkg::reg_addr_t rs,
      input rv_core_pkg::word_t exp);
    issue(asm_s('0, rs, 5'd0, rv_core_pkg::MW_W));
    check_word(what, exp, mem_wdata);
    check_mask(what, 4'hf, mem_wmask);
  endtask

  task automatic set_reg(input rv_core_pkg::reg_addr_t rd, input rv_core_pkg::word_t val);
    rv_core_pkg::word_t hi;
    hi = (val + 32'h800) >> 12; // rounds up for a negative low part
    issue(asm_u(hi, rd, rv_core_pkg::OP_LUI));
    issue(asm_i(val, rd, 3'b000, rd, rv_core_pkg::OP_IMM));
  endtask

  task automatic wait_for_halt();
    int n;
    n = 0;
    while (!halt && n < 8) begin
      @(negedge clk);
      n++;
    end
    if (!halt) begin
      $display("halt did not rise within 8 cycles after ebreak");
      stop_on_error();
    end
  endtask

  task automatic test_reset();
    rv_core_pkg::word_t v;
    test_name = "test_reset";
    // fills every register, pc checked on each issue
    for (int r = 1; r < rv_core_pkg::NUM_REGS; r++) begin
      v = rand_bits(12);
      issue(asm_i(v, 5'd0, 3'b000, rv_core_pkg::reg_addr_t'(r), rv_core_pkg::OP_IMM));
      store_and_check("addi", rv_core_pkg::reg_addr_t'(r), sext12(v));
    end
  endtask

  task automatic test_upper_imm();
    rv_core_pkg::word_t imm;
    rv_core_pkg::word_t low;
    rv_core_pkg::word_t pc_at;
    test_name = "test_upper_imm";
    repeat (4) begin
      imm = rand_bits(20);
      issue(asm_u(imm, 5'd5, rv_core_pkg::OP_LUI));
      store_and_check("lui", 5'd5, {imm[19:0], 12'h000});
      imm = rand_bits(20);
      pc_at = exp_pc;
      issue(asm_u(imm, 5'd6, rv_core_pkg::OP_AUIPC));
      store_and_check("auipc", 5'd6, pc_at + {imm[19:0], 12'h000});
      low = rand_bits(12);
      issue(asm_i(low, 5'd6, 3'b000, 5'd7, rv_core_pkg::OP_IMM));
      store_and_check("addi", 5'd7, pc_at + {imm[19:0], 12'h000} + sext12(low));
    end
  endtask

  task automatic test_jumps();
    rv_core_pkg::word_t off;
    rv_core_pkg::word_t base;
    rv_core_pkg::word_t pc_at;
    test_name = "test_jumps";
    repeat (4) begin
      off = rand_bits(20) << 1; // even offset, 21 bit span
      pc_at = exp_pc;
      issue(asm_j(off, 5'd8));
      exp_pc = pc_at + {{11{off[20]}}, off[20:0]};
      store_and_check("jal link", 5'd8, pc_at + rv_core_pkg::PC_STEP);
      base = rand_bits(32);
      set_reg(5'd10, base);
      off = rand_bits(12); // may be odd
      pc_at = exp_pc;
      issue(asm_i(off, 5'd10, 3'b000, 5'd9, rv_core_pkg::OP_JALR));
      exp_pc = (base + sext12(off)) & ~32'h1;
      store_and_check("jalr link", 5'd9, pc_at + rv_core_pkg::PC_STEP);
    end
  endtask

  task automatic test_loads();
    rv_core_pkg::mem_width_e widths [5];
    rv_core_pkg::word_t addr;
    rv_core_pkg::word_t w;
    logic aligned;
    string what;
    test_name = "test_loads";
    widths = '{rv_core_pkg::MW_B, rv_core_pkg::MW_H, rv_core_pkg::MW_W,
               rv_core_pkg::MW_BU, rv_core_pkg::MW_HU};
    for (int k = 0; k < 4; k++) begin
      addr = 32'h100 + rv_core_pkg::word_t'(4 * k);
      w = rand_bits(32);
      set_reg(5'd14, w);
      issue(asm_s(addr, 5'd14, 5'd0, rv_core_pkg::MW_W)); // place the word
      for (int off = 0; off < 4; off++) begin
        for (int j = 0; j < 5; j++) begin
          case (widths[j])
            rv_core_pkg::MW_W: aligned = (off == 0);
            rv_core_pkg::MW_H, rv_core_pkg::MW_HU: aligned = (off % 2 == 0);
            default: aligned = 1'b1;
          endcase
          if (aligned) begin
            what = $sformatf("%s at +%0d", widths[j].name(), off);
            issue(asm_i(addr + rv_core_pkg::word_t'(off), 5'd0, widths[j], 5'd11,
                        rv_core_pkg::OP_LOAD));
            check_word({what, " addr"}, addr, mem_addr);
            check_bit({what, " ren"}, 1'b1, mem_ren);
            store_and_check(what, 5'd11, load_expect(w, widths[j], off));
          end
        end
      end
    end
  endtask

  task automatic test_stores();
    rv_core_pkg::mem_width_e wd;
    rv_core_pkg::word_t base;
    rv_core_pkg::word_t d;
    rv_core_pkg::word_t old;
    rv_core_pkg::wmask_t lanes;
    string what;
    test_name = "test_stores";
    for (int off = 0; off < 4; off++) begin
      for (int h = 0; h < 2; h++) begin
        wd = (h == 1) ? rv_core_pkg::MW_H : rv_core_pkg::MW_B;
        if (h == 0 || off % 2 == 0) begin
          what = $sformatf("%s at +%0d", wd.name(), off);
          base = 32'h200 + rv_core_pkg::word_t'(8 * off + 4 * h); // fresh word each time
          d = rand_bits(32);
          set_reg(5'd12, d);
          old = mem[base[9:2]];
          issue(asm_s(base + rv_core_pkg::word_t'(off), 5'd12, 5'd0, wd));
          lanes = (h == 1) ? (4'b0011 << off) : (4'b0001 << off);
          check_mask({what, " mask"}, lanes, mem_wmask);
          issue(nop()); // store lands at this edge
          check_word({what, " word"}, merge_lanes(old, d << (8 * off), lanes),
                     mem[base[9:2]]);
        end
      end
    end
  endtask

  task automatic test_ebreak();
    rv_core_pkg::word_t keep;
    rv_core_pkg::word_t halt_pc;
    test_name = "test_ebreak";
    keep = rand_bits(32);
    set_reg(5'd13, keep);
    halt_pc = exp_pc;
    issue(rv_core_pkg::EBREAK_INST);
    wait_for_halt();
    exp_pc = halt_pc;
    repeat (4) begin
      issue(asm_i(32'h1, 5'd13, 3'b000, 5'd13, rv_core_pkg::OP_IMM));
      check_bit("halt held", 1'b1, halt);
      exp_pc = halt_pc;
    end
    issue(asm_s(32'h300, 5'd13, 5'd0, rv_core_pkg::MW_W));
    check_bit("store blocked", 1'b0, mem_wen);
    exp_pc = halt_pc;
    issue(asm_i(32'h1, 5'd13, 3'b000, 5'd13, rv_core_pkg::OP_IMM)); // parked until reset
    @(posedge clk);
    #0.5;
    apply_reset();
    store_and_check("after reset", 5'd13, keep + 32'h1);
  endtask

  initial begin
    rst = 1'b1;
    inst = nop();
    lfsr_q = 32'hbb9e_57ef;
    exp_pc = rv_core_pkg::RESET_PC;
    test_name = "startup";
    apply_reset();
    test_reset();
    test_upper_imm();
    test_jumps();
    test_loads();
    test_stores();
    test_ebreak();
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// File: build.f
src/rv_core_pkg.sv
src/decode_if.sv
src/rf_if.sv
src/inst_decode.sv
src/reg_file.sv
src/lsu_align.sv
src/exec_unit.sv
src/rv_core_top.sv
bench/core_chk.sv
bench/core_tb.sv

// File: run.sh
#!/usr/bin/env bash
# compile the core testbench with Verilator and run it
cd "$(dirname "$0")" &&
  verilator --binary --assert --top-module core_tb -f build.f -o core_sim &&
  ./obj_dir/core_sim ||
  exit 1
